// File: common/eth_rx_pkg.sv
package eth_rx_pkg;

	//////////////////////////////////////////////////////////////////////
	// Frame bus after alignment

	// Bytes per beat, first byte in the top lane
	localparam int frame_bytes = 16;
	localparam int frame_data_w = frame_bytes * 8;

	// Frame check sequence as it sits on the wire
	localparam int fcs_w = 32;

	typedef logic [frame_data_w-1:0] beat_t;

	// Holds 0 to 16 valid bytes
	typedef logic [$clog2(frame_bytes+1)-1:0] byte_count_t;

	typedef logic [fcs_w-1:0] fcs_t;

	//////////////////////////////////////////////////////////////////////
	// Framer states

	typedef enum logic [1:0] {
		// Hunting for a start character
		st_idle,
		// Preamble seen, checking the first data beat
		st_first,
		// Passing frame data
		st_active
	} rx_state_t;

endpackage

// File: common/xlgmii_pkg.sv
package xlgmii_pkg;

	//////////////////////////////////////////////////////////////////////
	// XLGMII beat geometry

	// One control bit per byte lane
	localparam int xlgmii_lanes = 16;

	// Lane 15 sits in the top byte and is first on the wire
	localparam int xlgmii_data_w = xlgmii_lanes * 8;

	typedef logic [xlgmii_data_w-1:0] xlgmii_beat_t;

	//////////////////////////////////////////////////////////////////////
	// Control characters

	// Only valid in a lane whose control bit is set
	typedef enum logic [7:0] {
		// Inter-frame fill
		ctl_idle      = 8'h07,
		// Low power idle
		ctl_lpi       = 8'h06,
		// Always in the first lane of a half
		ctl_start     = 8'hfb,
		// Any lane, first byte after the FCS
		ctl_terminate = 8'hfd,
		// Explicit PCS error
		ctl_error     = 8'hfe,
		// Link fault ordered set
		ctl_sequence  = 8'h9c
	} xlgmii_ctl_t;

endpackage

// File: filelist.f
common/xlgmii_pkg.sv
common/eth_rx_pkg.sv
rx_mac/xlg_rx_lane_decode.sv
rx_mac/xlg_rx_framer.sv
rx_mac/xlg_rx_fcs_strip.sv
rx_mac/crc32_eth_x128.sv
rx_mac/xlg_rx_fcs_check.sv
src/xlg_rx_mac.sv
sim/xlg_rx_mac_checker.sv
sim/tb_xlg_rx_mac.sv

// File: rx_mac/crc32_eth_x128.sv
`timescale 1ns/100ps

module crc32_eth_x128 #(
	parameter int crc_stages = 2
) (
	input  logic                    rx_clk,
	input  logic                    rst_n,
	input  logic                    crc_reset,
	input  logic                    crc_update,
	input  logic                    crc_last,
	input  eth_rx_pkg::byte_count_t crc_len,
	input  eth_rx_pkg::beat_t       crc_din,
	output eth_rx_pkg::fcs_t        crc_result
);
	import eth_rx_pkg::*;

	// Reflected form of 0x04c11db7
	localparam fcs_t crc_poly = 32'hedb88320;

	fcs_t crc_q;
	fcs_t crc_base;
	fcs_t crc_next;
	fcs_t crc_wire;
	fcs_t pipe [crc_stages];

	// Top len bytes, each byte LSB first
	function automatic fcs_t crc_bytes(fcs_t crc_in, beat_t din, byte_count_t len);
		fcs_t c;
		logic fb;
		c = crc_in;
		for (int k = 0; k < frame_bytes; k++)
			if (k < len)
				for (int b = 0; b < 8; b++) begin
					fb = c[0] ^ din[120 - 8*k + b];
					c  = {1'b0, c[31:1]} ^ (fb ? crc_poly : '0);
				end
		return c;
	endfunction

	// Start beat seeds the CRC with all ones
	assign crc_base = crc_reset ? '1 : crc_q;
	assign crc_next = crc_update ? crc_bytes(crc_base, crc_din, crc_len) : crc_base;

	// Inverted, first wire byte in the top lane
	assign crc_wire = {~crc_next[7:0], ~crc_next[15:8], ~crc_next[23:16], ~crc_next[31:24]};

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			crc_q <= '1;
			for (int i = 0; i < crc_stages; i++)
				pipe[i] <= '0;
		end else begin
			crc_q <= crc_next;
			// Result captured only on the last beat, then ripples out
			if (crc_last)
				pipe[0] <= crc_wire;
			for (int i = 1; i < crc_stages; i++)
				pipe[i] <= pipe[i-1];
		end
	end

	assign crc_result = pipe[crc_stages-1];

endmodule

// File: rx_mac/xlg_rx_fcs_check.sv
`timescale 1ns/100ps

module xlg_rx_fcs_check #(
	parameter int crc_stages = 2
) (
	input  logic                    rx_clk,
	input  logic                    rst_n,
	input  logic                    st_start,
	input  logic                    st_data_valid,
	input  eth_rx_pkg::byte_count_t st_bytes_valid,
	input  eth_rx_pkg::beat_t       st_data,
	input  logic                    st_commit,
	input  logic                    st_drop,
	input  eth_rx_pkg::fcs_t        fcs_expected,
	input  eth_rx_pkg::fcs_t        crc_result,
	output logic                    frame_start,
	output logic                    frame_data_valid,
	output eth_rx_pkg::byte_count_t frame_bytes_valid,
	output eth_rx_pkg::beat_t       frame_data,
	output logic                    frame_commit,
	output logic                    frame_drop
);
	import eth_rx_pkg::*;

	// One slot of the delay line
	typedef struct packed {
		logic        start;
		logic        data_valid;
		byte_count_t bytes_valid;
		beat_t       data;
		logic        commit;
		logic        drop;
		fcs_t        fcs;
	} slot_t;

	slot_t dly [crc_stages];
	slot_t tail;
	logic  fcs_ok;

	// Tail lines up with the CRC output
	assign tail   = dly[crc_stages-1];
	assign fcs_ok = (crc_result == tail.fcs);

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < crc_stages; i++)
				dly[i] <= '0;
			frame_start       <= 1'b0;
			frame_data_valid  <= 1'b0;
			frame_bytes_valid <= '0;
			frame_data        <= '0;
			frame_commit      <= 1'b0;
			frame_drop        <= 1'b0;
		end else begin
			dly[0] <= '{st_start, st_data_valid, st_bytes_valid, st_data,
				st_commit, st_drop, fcs_expected};
			for (int i = 1; i < crc_stages; i++)
				dly[i] <= dly[i-1];

			frame_start       <= tail.start;
			frame_data_valid  <= tail.data_valid;
			frame_bytes_valid <= tail.bytes_valid;
			frame_data        <= tail.data;
			// Bad FCS turns the commit into a drop
			frame_commit      <= tail.commit && fcs_ok && !tail.drop;
			frame_drop        <= tail.drop || (tail.commit && !fcs_ok);
		end
	end

endmodule

// File: rx_mac/xlg_rx_fcs_strip.sv
`timescale 1ns/100ps

module xlg_rx_fcs_strip (
	input  logic                    rx_clk,
	input  logic                    rst_n,
	input  logic                    al_start,
	input  logic                    al_data_valid,
	input  eth_rx_pkg::byte_count_t al_bytes_valid,
	input  eth_rx_pkg::beat_t       al_data,
	input  logic                    al_commit,
	input  logic                    al_drop,
	output logic                    st_start,
	output logic                    st_data_valid,
	output eth_rx_pkg::byte_count_t st_bytes_valid,
	output eth_rx_pkg::beat_t       st_data,
	output logic                    st_commit,
	output logic                    st_drop,
	output eth_rx_pkg::fcs_t        fcs_expected
);
	import eth_rx_pkg::*;

	// Held beat, one behind the framer
	logic        h_start;
	logic        h_data_valid;
	byte_count_t h_bytes_valid;
	beat_t       h_data;
	logic        h_commit;
	logic        h_drop;

	logic        h_full;
	logic        tail_short;
	logic [63:0] straddle;

	assign h_full = h_data_valid && (h_bytes_valid == byte_count_t'(frame_bytes)) && !h_commit;
	// Final beat too short to hold the whole FCS
	assign tail_short = al_commit && (al_bytes_valid < byte_count_t'(4));
	// FCS split across the held beat and the final one
	assign straddle = {h_data[31:0], al_data[127:96]};

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			h_start        <= 1'b0;
			h_data_valid   <= 1'b0;
			h_bytes_valid  <= '0;
			h_data         <= '0;
			h_commit       <= 1'b0;
			h_drop         <= 1'b0;
			st_start       <= 1'b0;
			st_data_valid  <= 1'b0;
			st_bytes_valid <= '0;
			st_data        <= '0;
			st_commit      <= 1'b0;
			st_drop        <= 1'b0;
			fcs_expected   <= '0;
		end else begin
			h_start        <= al_start;
			h_data_valid   <= al_data_valid;
			h_bytes_valid  <= al_bytes_valid;
			h_data         <= al_data;
			h_commit       <= al_commit;
			h_drop         <= al_drop;

			st_start       <= h_start;
			st_data        <= h_data;
			st_drop        <= h_drop;
			st_data_valid  <= 1'b0;
			st_bytes_valid <= '0;
			st_commit      <= 1'b0;

			if (h_full && tail_short) begin
				// Frame ends early in the next beat, this one loses its FCS bytes
				st_data_valid  <= 1'b1;
				st_bytes_valid <= byte_count_t'(12) + al_bytes_valid;
				st_commit      <= 1'b1;
				fcs_expected   <= straddle[(32 - 8*al_bytes_valid) +: 32];
			end else if (h_full) begin
				// At least 4 bytes follow, whole beat is payload
				st_data_valid  <= 1'b1;
				st_bytes_valid <= byte_count_t'(frame_bytes);
			end else if (h_commit && (h_bytes_valid >= byte_count_t'(4))) begin
				// FCS entirely inside the last beat
				st_data_valid  <= (h_bytes_valid != byte_count_t'(4));
				st_bytes_valid <= h_bytes_valid - byte_count_t'(4);
				st_commit      <= 1'b1;
				fcs_expected   <= h_data[(128 - 8*h_bytes_valid) +: 32];
			end
		end
	end

endmodule

// File: rx_mac/xlg_rx_framer.sv
`timescale 1ns/100ps

module xlg_rx_framer (
	input  logic                                    rx_clk,
	input  logic                                    rst_n,
	input  xlgmii_pkg::xlgmii_beat_t                dec_data,
	input  logic                                    start_left,
	input  logic                                    start_right,
	input  logic                                    ctl_left,
	input  logic                                    ctl_left_low,
	input  logic                                    ctl_right,
	input  logic                                    ctl_right_low,
	input  logic [xlgmii_pkg::xlgmii_lanes-1:0]     end_found,
	input  logic [xlgmii_pkg::xlgmii_lanes-1:0]     err_found,
	output logic                                    al_start,
	output logic                                    al_data_valid,
	output eth_rx_pkg::byte_count_t                 al_bytes_valid,
	output eth_rx_pkg::beat_t                       al_data,
	output logic                                    al_commit,
	output logic                                    al_drop
);
	import eth_rx_pkg::*;

	rx_state_t   state;
	// Set when the start was in lane 7, beats are then already aligned
	logic        phase;
	// A left-phase frame left bytes in the low half of its last beat
	logic        final_word;
	byte_count_t last_valid;
	logic [63:0] low_ff;
	beat_t       aligned;
	byte_count_t end_bytes;

	// Left phase borrows the low half of the previous beat
	assign aligned = phase ? dec_data : {low_ff, dec_data[127:64]};

	// Raw beat bytes ahead of the first terminate
	always_comb begin
		end_bytes = '0;
		for (int i = 0; i < 16; i++)
			if (end_found[i])
				end_bytes = byte_count_t'(15 - i);
	end

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			state          <= st_idle;
			phase          <= 1'b0;
			final_word     <= 1'b0;
			last_valid     <= '0;
			low_ff         <= '0;
			al_start       <= 1'b0;
			al_data_valid  <= 1'b0;
			al_bytes_valid <= '0;
			al_data        <= '0;
			al_commit      <= 1'b0;
			al_drop        <= 1'b0;
		end else begin
			// Pulses default low
			al_start       <= 1'b0;
			al_data_valid  <= 1'b0;
			al_bytes_valid <= '0;
			al_data        <= aligned;
			al_commit      <= 1'b0;
			al_drop        <= 1'b0;
			low_ff         <= dec_data[63:0];

			case (state)

				//////////////////////////////////////////////////////////////////////
				// Between frames

				st_idle: begin
					// Tail of a left-phase frame goes out here
					if (final_word) begin
						final_word     <= 1'b0;
						al_data        <= {low_ff, 64'h0};
						al_data_valid  <= 1'b1;
						al_bytes_valid <= last_valid;
						al_commit      <= 1'b1;
					end
					// Left start, right half already holds frame data
					if (start_left) begin
						if (!(ctl_left_low || ctl_right)) begin
							phase <= 1'b0;
							state <= st_first;
						end
					end else if (start_right && !ctl_right_low) begin
						phase <= 1'b1;
						state <= st_first;
					end
				end

				//////////////////////////////////////////////////////////////////////
				// First full data beat

				st_first: begin
					// Frames are at least 64 bytes, so control here means a runt
					if (ctl_left || ctl_right)
						state <= st_idle;
					else begin
						al_start       <= 1'b1;
						al_data_valid  <= 1'b1;
						al_bytes_valid <= byte_count_t'(frame_bytes);
						state          <= st_active;
					end
				end

				//////////////////////////////////////////////////////////////////////
				// Frame body and end

				st_active: begin
					al_data_valid  <= 1'b1;
					al_bytes_valid <= byte_count_t'(frame_bytes);
					// Bad character, or control with no terminate
					if ((|err_found) || (!(|end_found) && (ctl_left || ctl_right))) begin
						al_data_valid  <= 1'b0;
						al_bytes_valid <= '0;
						al_drop        <= 1'b1;
						state          <= st_idle;
					end else if (ctl_left || ctl_right) begin
						if (phase || (|end_found[15:8])) begin
							al_commit      <= 1'b1;
							// Aligned: terminate lane gives the count directly
							al_bytes_valid <= phase ? end_bytes : end_bytes + byte_count_t'(8);
							al_data_valid  <= !phase || (end_bytes != '0);
							// Next frame may start in lane 7 of this beat
							if (start_right && !ctl_right_low) begin
								phase <= 1'b1;
								state <= st_first;
							end else
								state <= st_idle;
						end else begin
							// Terminate in the right half of a left-phase frame
							al_commit  <= end_found[7];
							final_word <= !end_found[7];
							last_valid <= end_bytes - byte_count_t'(8);
							state      <= st_idle;
						end
					end
				end

				default: state <= st_idle;

			endcase
		end
	end

endmodule

// File: rx_mac/xlg_rx_lane_decode.sv
`timescale 1ns/100ps

module xlg_rx_lane_decode (
	input  logic                                    rx_clk,
	input  logic                                    rst_n,
	input  logic [xlgmii_pkg::xlgmii_lanes-1:0]     xlgmii_ctl,
	input  xlgmii_pkg::xlgmii_beat_t                xlgmii_data,
	output xlgmii_pkg::xlgmii_beat_t                dec_data,
	output logic                                    start_left,
	output logic                                    start_right,
	output logic                                    ctl_left,
	output logic                                    ctl_left_low,
	output logic                                    ctl_right,
	output logic                                    ctl_right_low,
	output logic [xlgmii_pkg::xlgmii_lanes-1:0]     end_found,
	output logic [xlgmii_pkg::xlgmii_lanes-1:0]     err_found
);
	import xlgmii_pkg::*;

	logic [xlgmii_lanes-1:0] term_lane;
	logic [xlgmii_lanes-1:0] bad_lane;

	// Per-lane classification of the raw beat
	always_comb begin
		logic [7:0] lane;
		for (int i = 0; i < xlgmii_lanes; i++) begin
			lane = xlgmii_data[i*8 +: 8];
			term_lane[i] = xlgmii_ctl[i] && (lane == ctl_terminate);
			// Error char is not in the list, so it flags here too
			bad_lane[i] = xlgmii_ctl[i] &&
				!(lane inside {ctl_idle, ctl_lpi, ctl_sequence, ctl_start, ctl_terminate});
		end
	end

	// Flags registered with the data they describe
	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			dec_data      <= '0;
			start_left    <= 1'b0;
			start_right   <= 1'b0;
			ctl_left      <= 1'b0;
			ctl_left_low  <= 1'b0;
			ctl_right     <= 1'b0;
			ctl_right_low <= 1'b0;
			end_found     <= '0;
			err_found     <= '0;
		end else begin
			dec_data      <= xlgmii_data;
			// Start is only legal in lane 15 or lane 7
			start_left    <= xlgmii_ctl[15] && (xlgmii_data[127:120] == ctl_start);
			start_right   <= xlgmii_ctl[7] && (xlgmii_data[63:56] == ctl_start);
			// Low variants skip the lane that may hold the start
			ctl_left      <= |xlgmii_ctl[15:8];
			ctl_left_low  <= |xlgmii_ctl[14:8];
			ctl_right     <= |xlgmii_ctl[7:0];
			ctl_right_low <= |xlgmii_ctl[6:0];
			end_found     <= term_lane;
			err_found     <= bad_lane;
		end
	end

endmodule

// File: sim/tb_xlg_rx_mac.sv
`timescale 1ns/100ps

module tb_xlg_rx_mac;
	import xlgmii_pkg::*;
	import eth_rx_pkg::*;

	localparam int frame_good    = 0;
	localparam int frame_bad_fcs = 1;
	localparam int frame_ctl_err = 2;
	localparam int frame_runt    = 3;

	logic                    rx_clk;
	logic                    rst_n;
	logic [xlgmii_lanes-1:0] xlgmii_ctl;
	xlgmii_beat_t            xlgmii_data;
	logic                    frame_start;
	logic                    frame_data_valid;
	byte_count_t             frame_bytes_valid;
	beat_t                   frame_data;
	logic                    frame_commit;
	logic                    frame_drop;

	// Wire stream, one entry per lane, first on the wire first
	logic [7:0]  lane_q [$];
	logic        ctl_q [$];
	// Payload of all expected frames back to back
	logic [7:0]  exp_bytes [$];
	int          exp_len_q [$];
	bit          exp_good_q [$];
	// Clear when only a prefix of the payload arrives
	bit          exp_full_q [$];
	string       exp_name_q [$];

	int unsigned lcg_state = 4;
	int          stream_beats = 0;
	int          frames_total = 0;
	int          frames_done = 0;
	int          frames_failed = 0;
	int          starts_seen = 0;
	int          errors = 0;

	xlg_rx_mac #(.crc_stages(2)) dut (
		.rx_clk, .rst_n, .xlgmii_ctl, .xlgmii_data,
		.frame_start, .frame_data_valid, .frame_bytes_valid, .frame_data,
		.frame_commit, .frame_drop
	);

	//////////////////////////////////////////////////////////////////////
	// Reference model

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state >> 8;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'(lcg_next() % (hi - lo + 1));
	endfunction

	// Reflected CRC-32, one byte LSB first
	function automatic fcs_t crc_step(input fcs_t crc, input logic [7:0] b);
		fcs_t c;
		c = crc;
		for (int i = 0; i < 8; i++)
			c = (c[0] ^ b[i]) ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
		return c;
	endfunction

	// Longer payload so the terminate falls at lane offset term_off
	function automatic int fit_len(input int len, input bit right, input int term_off);
		int now_off;
		now_off = ((right ? 8 : 0) + 12 + len) % 16;
		return len + (term_off - now_off + 16) % 16;
	endfunction

	// Zero every byte past the first n
	function automatic beat_t mask_beat(input beat_t d, input int n);
		beat_t m;
		m = d;
		for (int k = 0; k < 16; k++)
			if (k >= n)
				m[127-8*k -: 8] = 8'h00;
		return m;
	endfunction

	task automatic put_lane(input logic c, input logic [7:0] b);
		ctl_q.push_back(c);
		lane_q.push_back(b);
	endtask

	task automatic pad_to(input int off);
		while (lane_q.size() % 16 != off)
			put_lane(1'b1, ctl_idle);
	endtask

	// Preamble, payload, FCS and terminate, plus the expected record
	task automatic add_frame(input string name, input int len, input bit right,
			input int kind, input bit tight);
		logic [7:0] pay [$];
		fcs_t       crc;
		if (!tight)
			repeat (16) put_lane(1'b1, ctl_idle);
		// Start sits in lane 15 or lane 7
		pad_to(right ? 8 : 0);
		put_lane(1'b1, ctl_start);
		repeat (6) put_lane(1'b0, 8'h55);
		put_lane(1'b0, 8'hd5);
		if (kind == frame_runt) begin
			// Terminate inside the first beat after the start
			repeat (right ? 5 : 13) put_lane(1'b0, 8'(lcg_next()));
			put_lane(1'b1, ctl_terminate);
		end else begin
			crc = '1;
			for (int i = 0; i < len; i++) begin
				pay.push_back(8'(lcg_next()));
				crc = crc_step(crc, pay[i]);
			end
			crc = ~crc;
			if (kind == frame_bad_fcs)
				crc[15:8] = ~crc[15:8];
			for (int i = 0; i < len; i++)
				if (kind == frame_ctl_err && i == 40)
					put_lane(1'b1, ctl_error);
				else
					put_lane(1'b0, pay[i]);
			// FCS goes out low byte first
			for (int i = 0; i < 4; i++)
				put_lane(1'b0, crc[8*i +: 8]);
			put_lane(1'b1, ctl_terminate);
			foreach (pay[i])
				exp_bytes.push_back(pay[i]);
			exp_len_q.push_back(len);
			exp_good_q.push_back(kind == frame_good);
			exp_full_q.push_back(kind != frame_ctl_err);
			exp_name_q.push_back(name);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic check_beat(input beat_t got, input byte_count_t got_n,
			input beat_t exp, input byte_count_t exp_n);
		if (got_n !== exp_n) begin
			errors++;
			$display("mismatch at %0t: frame_bytes_valid got %0d expected %0d",
				$time, got_n, exp_n);
		end
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: frame_data got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic check_status(input logic got_commit, input logic got_drop, input bit good);
		if (got_commit !== logic'(good)) begin
			errors++;
			$display("mismatch at %0t: frame_commit got %b expected %b", $time, got_commit, good);
		end
		if (got_drop !== logic'(!good)) begin
			errors++;
			$display("mismatch at %0t: frame_drop got %b expected %b", $time, got_drop, !good);
		end
	endtask

	task automatic check_fcs(input fcs_t got, input fcs_t exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: payload crc got %h expected %h", $time, got, exp);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Clock, stimulus and watchdog

	initial begin
		rx_clk = 1'b0;
		forever #5 rx_clk = ~rx_clk;
	end

	initial begin
		rst_n       = 1'b1;
		xlgmii_ctl  = '1;
		xlgmii_data = {xlgmii_lanes{8'h07}};
		// Every terminate lane in both phases
		for (int i = 0; i < 16; i++)
			add_frame("right_phase", fit_len(rand_range(60, 185), 1'b1, i), 1'b1, frame_good, 1'b0);
		for (int i = 0; i < 16; i++)
			add_frame("left_phase", fit_len(rand_range(60, 185), 1'b0, i), 1'b0, frame_good, 1'b0);
		add_frame("bad_fcs", rand_range(60, 200), rand_range(0, 1), frame_bad_fcs, 1'b0);
		add_frame("ctl_error", rand_range(60, 200), rand_range(0, 1), frame_ctl_err, 1'b0);
		add_frame("runt", 0, rand_range(0, 1), frame_runt, 1'b0);
		add_frame("runt_recovery", rand_range(60, 200), rand_range(0, 1), frame_good, 1'b0);
		// First frame ends in the left half, second starts in lane 7 of that beat
		for (int i = 0; i < 2; i++) begin
			add_frame("back_to_back_a", fit_len(rand_range(60, 185), i[0], rand_range(0, 7)),
				i[0], frame_good, 1'b0);
			add_frame("back_to_back_b", rand_range(60, 200), 1'b1, frame_good, 1'b1);
		end
		pad_to(0);
		repeat (32 * 16) put_lane(1'b1, ctl_idle);
		frames_total = exp_len_q.size();
		stream_beats = lane_q.size() / 16;

		// Falling edge after time zero so every flop sees it
		#1 rst_n = 1'b0;
		repeat (5) @(posedge rx_clk);
		#1 rst_n = 1'b1;
		while (lane_q.size() > 0) begin
			@(posedge rx_clk);
			#1;
			for (int k = 0; k < 16; k++) begin
				xlgmii_ctl[15-k]           = ctl_q.pop_front();
				xlgmii_data[127-8*k -: 8]  = lane_q.pop_front();
			end
		end
		wait (exp_len_q.size() == 0);

		if (starts_seen != frames_total) begin
			errors++;
			$display("Error: %0d frame starts seen for %0d frames sent", starts_seen, frames_total);
		end
		if (dut.u_checker.fail_count != 0) begin
			errors += dut.u_checker.fail_count;
			$display("Error: %0d assertion failures in the checker", dut.u_checker.fail_count);
		end
		$display("Frames checked %0d of %0d, %0d failed, %0d errors",
			frames_done, frames_total, frames_failed, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// Stream length plus margin for reset and pipeline drain
	initial begin
		wait (stream_beats > 0);
		#((stream_beats + 50) * 10);
		$display("Timeout: frames still outstanding after %0d cycles", stream_beats + 50);
		$display("SIMULATION FAILED");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Comparison, outputs sampled on the falling edge

	initial begin
		bit    in_frame;
		int    cnt;
		int    rx_count;
		int    err_mark;
		fcs_t  rx_crc;
		fcs_t  exp_crc;
		beat_t exp_beat;
		in_frame = 1'b0;
		rx_count = 0;
		err_mark = 0;
		rx_crc   = '1;
		forever begin
			@(negedge rx_clk);
			if (frame_start) begin
				starts_seen++;
				if (in_frame || exp_len_q.size() == 0) begin
					errors++;
					$display("Error at %0t: frame_start while no new frame was due", $time);
				end else begin
					in_frame = 1'b1;
					rx_count = 0;
					rx_crc   = '1;
					err_mark = errors;
				end
			end
			if (in_frame && frame_data_valid) begin
				// All beats full except the last
				cnt = exp_len_q[0] - rx_count;
				cnt = (cnt > 16) ? 16 : ((cnt < 0) ? 0 : cnt);
				exp_beat = '0;
				for (int k = 0; k < cnt; k++)
					exp_beat[127-8*k -: 8] = exp_bytes[rx_count + k];
				check_beat(mask_beat(frame_data, frame_bytes_valid), frame_bytes_valid,
					exp_beat, byte_count_t'(cnt));
				for (int k = 0; k < frame_bytes_valid && k < 16; k++)
					rx_crc = crc_step(rx_crc, frame_data[127-8*k -: 8]);
				rx_count += frame_bytes_valid;
			end
			if (frame_commit || frame_drop) begin
				if (!in_frame) begin
					errors++;
					$display("Error at %0t: frame ended without a frame_start", $time);
				end else begin
					check_status(frame_commit, frame_drop, exp_good_q[0]);
					if (exp_full_q[0]) begin
						exp_crc = '1;
						for (int i = 0; i < exp_len_q[0]; i++)
							exp_crc = crc_step(exp_crc, exp_bytes[i]);
						check_fcs(rx_crc, exp_crc);
					end
					if (errors != err_mark)
						frames_failed++;
					$display("%s frame %0d: %s", exp_name_q[0], frames_done,
						(errors == err_mark) ? "ok" : "wrong");
					repeat (exp_len_q[0]) exp_bytes.delete(0);
					exp_len_q.delete(0);
					exp_good_q.delete(0);
					exp_full_q.delete(0);
					exp_name_q.delete(0);
					frames_done++;
					in_frame = 1'b0;
				end
			end
		end
	end

endmodule

// File: sim/xlg_rx_mac_checker.sv
`timescale 1ns/100ps

module xlg_rx_mac_checker (
	input  logic                    rx_clk,
	input  logic                    rst_n,
	input  logic                    frame_start,
	input  logic                    frame_data_valid,
	input  eth_rx_pkg::byte_count_t frame_bytes_valid,
	input  eth_rx_pkg::beat_t       frame_data,
	input  logic                    frame_commit,
	input  logic                    frame_drop
);
	import eth_rx_pkg::*;

	// Count of assertion failures
	int fail_count = 0;

	// A frame ends one way only
	commit_drop_excl: assert property (@(posedge rx_clk) disable iff (!rst_n)
		!(frame_commit && frame_drop))
	else begin
		fail_count++;
		$error("frame_commit and frame_drop high in the same cycle");
	end

	// Never more bytes than lanes
	bytes_in_range: assert property (@(posedge rx_clk) disable iff (!rst_n)
		frame_data_valid |-> (frame_bytes_valid <= byte_count_t'(frame_bytes)))
	else begin
		fail_count++;
		$error("frame_bytes_valid above 16 while frame_data_valid is high");
	end

	// Whole frame bus quiet in reset
	outputs_in_reset: assert property (@(posedge rx_clk)
		!rst_n |-> (!(frame_start || frame_data_valid || frame_commit || frame_drop)
			&& (frame_bytes_valid == '0) && (frame_data == '0)))
	else begin
		fail_count++;
		$error("frame outputs not low while rst_n is low");
	end

endmodule

bind xlg_rx_mac xlg_rx_mac_checker u_checker (
	.rx_clk, .rst_n, .frame_start, .frame_data_valid, .frame_bytes_valid,
	.frame_data, .frame_commit, .frame_drop
);

// File: src/xlg_rx_mac.sv
`timescale 1ns/100ps

module xlg_rx_mac #(
	parameter int crc_stages = 2
) (
	input  logic                                rx_clk,
	input  logic                                rst_n,
	input  logic [xlgmii_pkg::xlgmii_lanes-1:0] xlgmii_ctl,
	input  xlgmii_pkg::xlgmii_beat_t            xlgmii_data,
	output logic                                frame_start,
	output logic                                frame_data_valid,
	output eth_rx_pkg::byte_count_t             frame_bytes_valid,
	output eth_rx_pkg::beat_t                   frame_data,
	output logic                                frame_commit,
	output logic                                frame_drop
);
	import xlgmii_pkg::*;
	import eth_rx_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Lane decode

	xlgmii_beat_t            dec_data;
	logic                    start_left;
	logic                    start_right;
	logic                    ctl_left;
	logic                    ctl_left_low;
	logic                    ctl_right;
	logic                    ctl_right_low;
	logic [xlgmii_lanes-1:0] end_found;
	logic [xlgmii_lanes-1:0] err_found;

	xlg_rx_lane_decode u_decode (
		.rx_clk, .rst_n, .xlgmii_ctl, .xlgmii_data, .dec_data,
		.start_left, .start_right, .ctl_left, .ctl_left_low,
		.ctl_right, .ctl_right_low, .end_found, .err_found
	);

	//////////////////////////////////////////////////////////////////////
	// Framing, FCS strip and check

	// Aligned bus
	logic        al_start, al_data_valid, al_commit, al_drop;
	byte_count_t al_bytes_valid;
	beat_t       al_data;

	// Payload-only bus
	logic        st_start, st_data_valid, st_commit, st_drop;
	byte_count_t st_bytes_valid;
	beat_t       st_data;
	fcs_t        fcs_expected;
	fcs_t        crc_result;

	xlg_rx_framer u_framer (
		.rx_clk, .rst_n, .dec_data, .start_left, .start_right,
		.ctl_left, .ctl_left_low, .ctl_right, .ctl_right_low, .end_found, .err_found,
		.al_start, .al_data_valid, .al_bytes_valid, .al_data, .al_commit, .al_drop
	);

	xlg_rx_fcs_strip u_strip (
		.rx_clk, .rst_n,
		.al_start, .al_data_valid, .al_bytes_valid, .al_data, .al_commit, .al_drop,
		.st_start, .st_data_valid, .st_bytes_valid, .st_data, .st_commit, .st_drop,
		.fcs_expected
	);

	crc32_eth_x128 #(.crc_stages(crc_stages)) u_crc (
		.rx_clk, .rst_n,
		.crc_reset  (st_start),
		.crc_update (st_data_valid),
		.crc_last   (st_commit),
		.crc_len    (st_bytes_valid),
		.crc_din    (st_data),
		.crc_result
	);

	xlg_rx_fcs_check #(.crc_stages(crc_stages)) u_check (
		.rx_clk, .rst_n,
		.st_start, .st_data_valid, .st_bytes_valid, .st_data, .st_commit, .st_drop,
		.fcs_expected, .crc_result,
		.frame_start, .frame_data_valid, .frame_bytes_valid, .frame_data,
		.frame_commit, .frame_drop
	);

endmodule
